//--- project.f
+incdir+hdl
hdl/lspcPkg.sv
hdl/busPort.sv
hdl/vramPort.sv
hdl/rasterTimer.sv
hdl/lspcCore.sv
bench/lspc_props.sv
bench/lspcTb.sv

//--- Makefile
TOP = lspcTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -Wno-fatal --top-module $(TOP) -f project.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

//--- bench/lspcTb.sv
`timescale 1ns/1ps
`include "lspc_defines.svh"

module lspcTb
	import lspcPkg::*;
();

	localparam int PERIOD = 4;
	localparam int FRAME = `LINE_PIXELS * `FRAME_LINES;
	// Cycle budgets of the six tests, then slack
	localparam int TEST_CYCLES = 2000 + 800 + 600 + 1500 + 4200 + 1600;
	localparam int MARGIN = 2000;

	logic clk24M = 1'b0;
	logic reset;
	logic wrStrobe;
	logic rdStrobe;
	regAddr_t regAddr;
	cpuWord_t wrData;
	cpuWord_t readData;
	logic rdValid;
	irqLevel_t ipl;

	// Reference model state
	logic [7:0] mSel;
	cpuWord_t mData;
	logic mRdPending;
	regAddr_t mRdAddr;
	logic mRdValid;
	cpuWord_t mReadData;
	cpuWord_t mVram [1 << `VRAM_AW];
	cpuWord_t mVramWord;
	vramAddr_t mAddr;
	cpuWord_t mMod;
	cpuWord_t mMode;
	timerCount_t mReload;
	timerCount_t mTimer;
	logic mTimerIrq;
	logic mVblank;
	int mPixel;
	int mLine;
	logic [7:0] mFrame;
	aaCount_t mAa;

	int errorCount = 0;
	int checkCount = 0;
	int testStart = 0;

	always #(PERIOD / 2) clk24M = ~clk24M;

	lspcCore dut
	(
		.clk24M(clk24M),
		.reset(reset),
		.wrStrobe(wrStrobe),
		.rdStrobe(rdStrobe),
		.regAddr(regAddr),
		.wrData(wrData),
		.readData(readData),
		.rdValid(rdValid),
		.ipl(ipl)
	);

	bind lspcCore lspcProps props
	(
		.clk24M(clk24M),
		.reset(reset),
		.rdStrobe(rdStrobe),
		.rdValid(rdValid),
		.ipl(ipl),
		.status(status),
		.regWrite(regWrite)
	);

	// Address-unique word for the initial VRAM fill
	function automatic cpuWord_t fillWord(int a);
		return {8'(a), ~8'(a)} ^ 16'hA5C3;
	endfunction

	function automatic irqLevel_t expectedIpl();
		if (mVblank)
			return 2'd1;
		else if (mTimerIrq)
			return 2'd2;
		return 2'd0;
	endfunction

	// Local check failures plus those of the bound assertions
	function automatic int totalErrors();
		return errorCount + dut.props.failCount;
	endfunction

	// One clock edge of the register block, all terms use pre-edge state
	task automatic stepModel(input logic inReset);
		logic pixWrap;
		logic frameWrap;
		logic [7:0] sel;
		cpuWord_t data;
		cpuWord_t readMux;
		pixWrap = mPixel == `LINE_PIXELS - 1;
		frameWrap = pixWrap && mLine == `FRAME_LINES - 1;
		sel = mSel;
		data = mData;
		case (mRdAddr)
			3'd0, 3'd1: readMux = mVramWord;
			3'd2: readMux = mMod;
			3'd3: readMux = {9'(mLine), 4'b0000, mAa};
			default: readMux = mMode;
		endcase
		mVramWord = mVram[mAddr[`VRAM_AW-1:0]];
		if (inReset)
		begin
			mSel = '0;
			mData = '0;
			mRdPending = 1'b0;
			mRdAddr = '0;
			mRdValid = 1'b0;
			mReadData = '0;
			mAddr = '0;
			mMod = '0;
			mMode = '0;
			mReload = '0;
			mTimer = '0;
			mTimerIrq = 1'b0;
			mVblank = 1'b0;
			mPixel = 0;
			mLine = 0;
			mFrame = '0;
			mAa = '0;
			return;
		end
		if (mRdPending)
			mReadData = readMux;
		mRdValid = mRdPending;
		mRdPending = rdStrobe;
		mRdAddr = regAddr;
		mSel = wrStrobe ? 8'(1 << regAddr) : 8'h00;
		mData = wrData;
		// VRAM write lands at the address before the increment
		if (sel[`REG_VRAMRW])
			mVram[mAddr[`VRAM_AW-1:0]] = data;
		if (sel[`REG_VRAMADDR])
			mAddr = data;
		else if (sel[`REG_VRAMRW])
			mAddr = mAddr + mMod;
		if (sel[`REG_VRAMMOD])
			mMod = data;
		if (mTimer == 32'd1 && mMode[`MODE_TIMER_IRQ])
			mTimerIrq = 1'b1;
		else if (sel[`REG_IRQACK] && data[0])
			mTimerIrq = 1'b0;
		if (frameWrap)
			mVblank = 1'b1;
		else if (sel[`REG_IRQACK] && data[1])
			mVblank = 1'b0;
		if (sel[`REG_TIMERLOW] && mMode[`MODE_RELOAD_LOW])
			mTimer = {mReload[31:16], data};
		else if (mTimer == 32'd1)
			mTimer = mReload;
		else if (mTimer != 32'd0)
			mTimer = mTimer - 32'd1;
		if (frameWrap)
		begin
			if (mFrame == mMode[15:8])
			begin
				mFrame = '0;
				if (!mMode[`MODE_AA_DISABLE])
					mAa = mAa + 3'd1;
			end
			else
				mFrame = mFrame + 8'd1;
		end
		if (sel[`REG_LSPCMODE])
			mMode = data;
		if (sel[`REG_TIMERHIGH])
			mReload[31:16] = data;
		if (sel[`REG_TIMERLOW])
			mReload[15:0] = data;
		mPixel = pixWrap ? 0 : mPixel + 1;
		if (frameWrap)
			mLine = 0;
		else if (pixWrap)
			mLine = mLine + 1;
	endtask

	always @(posedge clk24M)
		stepModel(reset);

	// Outputs are compared half a cycle after the edge
	always @(negedge clk24M)
	begin
		if (!reset)
		begin
			checkCount++;
			assert (ipl === expectedIpl())
			else
			begin
				errorCount++;
				$display("** Error at %0t ns: ipl expected %0d, got %0d", $time,
					expectedIpl(), ipl);
			end
			assert (!(rdValid && !mRdValid))
			else
			begin
				errorCount++;
				$display("rdValid pulsed at %0t ns with no read outstanding", $time);
			end
			if (rdValid && mRdValid)
			begin
				checkCount++;
				assert (readData === mReadData)
				else
				begin
					errorCount++;
					$display("** Error at %0t ns: readData expected %h, got %h", $time,
						mReadData, readData);
				end
			end
		end
	end

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk24M);
	endtask

	task automatic writeReg(input regAddr_t addr, input cpuWord_t data);
		@(posedge clk24M);
		wrStrobe <= 1'b1;
		regAddr <= addr;
		wrData <= data;
		@(posedge clk24M);
		wrStrobe <= 1'b0;
	endtask

	task automatic readReg(input regAddr_t addr);
		logic gotValid;
		gotValid = 1'b0;
		@(posedge clk24M);
		rdStrobe <= 1'b1;
		regAddr <= addr;
		@(posedge clk24M);
		rdStrobe <= 1'b0;
		for (int i = 0; i < 4 && !gotValid; i++)
		begin
			@(negedge clk24M);
			gotValid = rdValid;
		end
		assert (gotValid)
		else
		begin
			errorCount++;
			$display("Read of register %0d at %0t ns never raised rdValid", addr, $time);
		end
	endtask

	task automatic reportTest(input string name);
		int total;
		total = totalErrors();
		$display("Test %s finished with %0d errors", name, total - testStart);
		testStart = total;
	endtask

	task automatic vramBurst();
		vramAddr_t base;
		vramAddr_t addr;
		cpuWord_t step;
		int len;
		writeReg(`REG_VRAMMOD, 16'd1);
		writeReg(`REG_VRAMADDR, 16'd0);
		for (int i = 0; i < (1 << `VRAM_AW); i++)
			writeReg(`REG_VRAMRW, fillWord(i));
		repeat (3)
		begin
			base = 16'($urandom);
			step = 16'($urandom);
			len = $urandom_range(12, 4);
			writeReg(`REG_VRAMMOD, step);
			writeReg(`REG_VRAMADDR, base);
			repeat (len) writeReg(`REG_VRAMRW, 16'($urandom));
			// Word at the address left by the increments
			readReg(`REG_VRAMRW);
			addr = base;
			repeat (len)
			begin
				writeReg(`REG_VRAMADDR, addr);
				readReg(3'($urandom_range(1, 0)));
				addr = addr + step;
			end
		end
	endtask

	task automatic registerReadback();
		repeat (10)
		begin
			writeReg(`REG_VRAMMOD, 16'($urandom));
			writeReg(`REG_LSPCMODE, 16'($urandom));
			waitCycles($urandom_range(40, 0));
			readReg(`REG_VRAMMOD);
			readReg(3'($urandom_range(7, 4)));
			readReg(`REG_LSPCMODE);
		end
	endtask

	task automatic timerReload();
		int r;
		writeReg(`REG_IRQACK, 16'd3);
		repeat (4)
		begin
			r = $urandom_range(40, 8);
			writeReg(`REG_LSPCMODE, 16'h0003);
			writeReg(`REG_TIMERHIGH, 16'd0);
			writeReg(`REG_TIMERLOW, 16'(r));
			waitCycles(r + 4);
			writeReg(`REG_IRQACK, 16'd1);
			waitCycles(r / 2);
			writeReg(`REG_IRQACK, 16'd3);
		end
		writeReg(`REG_TIMERLOW, 16'd0);
		writeReg(`REG_IRQACK, 16'd3);
	endtask

	task automatic vblankInterrupt();
		logic found;
		writeReg(`REG_LSPCMODE, 16'h0003);
		writeReg(`REG_TIMERHIGH, 16'd0);
		writeReg(`REG_TIMERLOW, 16'd30);
		writeReg(`REG_IRQACK, 16'd3);
		repeat (2)
		begin
			found = 1'b0;
			for (int i = 0; i < 2 * FRAME && !found; i++)
			begin
				@(negedge clk24M);
				found = ipl == 2'd1;
			end
			assert (found)
			else
			begin
				errorCount++;
				$display("Vblank interrupt never showed on ipl by %0t ns", $time);
			end
			// Timer flag is pending under the vblank by now
			waitCycles(40);
			writeReg(`REG_IRQACK, 16'd2);
			waitCycles(20);
		end
		writeReg(`REG_TIMERLOW, 16'd0);
		writeReg(`REG_IRQACK, 16'd3);
	endtask

	task automatic autoAnimation();
		logic [7:0] speed;
		speed = 8'($urandom_range(2, 0));
		// Early in a frame, so the frame counter clears at the coming wrap
		@(negedge clk24M);
		while (mLine != 0 || mPixel >= 8)
			@(negedge clk24M);
		writeReg(`REG_LSPCMODE, {mFrame, 8'h04});
		waitCycles(FRAME);
		writeReg(`REG_LSPCMODE, {speed, 8'h00});
		repeat ((speed + 1) * 3)
		begin
			waitCycles(FRAME - 8);
			readReg(`REG_LSPCMODE);
		end
		writeReg(`REG_LSPCMODE, {speed, 8'h04});
		repeat (2)
		begin
			waitCycles(FRAME - 8);
			readReg(`REG_LSPCMODE);
		end
	endtask

	task automatic mixedTraffic();
		regAddr_t addr;
		repeat (200)
		begin
			addr = 3'($urandom_range(7, 0));
			if ($urandom_range(1, 0) == 1)
				writeReg(addr, 16'($urandom));
			else
				readReg(addr);
			waitCycles($urandom_range(3, 0));
		end
	endtask

	initial
	begin
		#((16 + TEST_CYCLES + MARGIN) * PERIOD);
		$display("Watchdog expired after %0d cycles, tests did not complete",
			16 + TEST_CYCLES + MARGIN);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h44a8_3055));
		reset = 1'b1;
		wrStrobe = 1'b0;
		rdStrobe = 1'b0;
		regAddr = '0;
		wrData = '0;
		repeat (16) @(posedge clk24M);
		reset <= 1'b0;
		vramBurst();
		reportTest("VRAM burst");
		registerReadback();
		reportTest("register readback");
		timerReload();
		reportTest("timer reload");
		vblankInterrupt();
		reportTest("vblank interrupt");
		autoAnimation();
		reportTest("auto-animation");
		mixedTraffic();
		reportTest("mixed traffic");
		waitCycles(4);
		$display("Tests: 6, checks: %0d, errors: %0d", checkCount, totalErrors());
		if (totalErrors() == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- bench/lspc_props.sv
`timescale 1ns/1ps
`include "lspc_defines.svh"

module lspcProps
	import lspcPkg::*;
(
	input logic clk24M,
	input logic reset,
	input logic rdStrobe,
	input logic rdValid,
	input irqLevel_t ipl,
	input rasterStatus_t status,
	input regWrite_t regWrite
);

	logic ackTimer;
	logic ackVblank;
	logic started;

	// Failed assertions so far
	int failCount = 0;

	assign ackTimer = regWrite.select[`REG_IRQACK] && regWrite.data[0];
	assign ackVblank = regWrite.select[`REG_IRQACK] && regWrite.data[1];

	// Marks the first clock edge seen
	always_ff @(posedge clk24M)
	begin
		started <= 1'b1;
	end

	// Fixed two-cycle read latency
	readLatency: assert property (@(posedge clk24M) disable iff (reset)
		rdValid == $past(rdStrobe, 2))
		else
		begin
			failCount++;
			$error("rdValid does not follow rdStrobe by exactly two cycles");
		end

	resetIpl: assert property (@(posedge clk24M)
		started && reset && $past(reset) |-> ipl == 2'd0)
		else
		begin
			failCount++;
			$error("ipl is not zero while reset is held");
		end

	// Flags are sticky until acknowledged
	timerHold: assert property (@(posedge clk24M) disable iff (reset)
		$past(status.timerIrq && !ackTimer) |-> status.timerIrq)
		else
		begin
			failCount++;
			$error("Timer flag dropped without an acknowledge");
		end

	vblankHold: assert property (@(posedge clk24M) disable iff (reset)
		$past(status.vblankIrq && !ackVblank) |-> status.vblankIrq)
		else
		begin
			failCount++;
			$error("Vblank flag dropped without an acknowledge");
		end

endmodule

//--- hdl/lspcCore.sv
`timescale 1ns/1ps

module lspcCore
	import lspcPkg::*;
(
	input logic clk24M,
	input logic reset,
	input logic wrStrobe,
	input logic rdStrobe,
	input regAddr_t regAddr,
	input cpuWord_t wrData,
	output cpuWord_t readData,
	output logic rdValid,
	output irqLevel_t ipl
);

	regWrite_t regWrite;
	cpuWord_t vramWord;
	cpuWord_t modWord;
	cpuWord_t modeWord;
	rasterStatus_t status;

	// CPU decode, read return and interrupt level
	busPort bus
	(
		.clk24M(clk24M),
		.reset(reset),
		.wrStrobe(wrStrobe),
		.rdStrobe(rdStrobe),
		.regAddr(regAddr),
		.wrData(wrData),
		.vramWord(vramWord),
		.modWord(modWord),
		.modeWord(modeWord),
		.status(status),
		.regWrite(regWrite),
		.readData(readData),
		.rdValid(rdValid),
		.ipl(ipl)
	);

	vramPort vram
	(
		.clk24M(clk24M),
		.reset(reset),
		.regWrite(regWrite),
		.vramWord(vramWord),
		.modWord(modWord)
	);

	// Video timing side
	rasterTimer timing
	(
		.clk24M(clk24M),
		.reset(reset),
		.regWrite(regWrite),
		.status(status),
		.modeWord(modeWord)
	);

endmodule

//--- hdl/rasterTimer.sv
`timescale 1ns/1ps
`include "lspc_defines.svh"

module rasterTimer
	import lspcPkg::*;
(
	input logic clk24M,
	input logic reset,
	input regWrite_t regWrite,
	output rasterStatus_t status,
	output cpuWord_t modeWord
);

	localparam int PIXEL_W = $clog2(`LINE_PIXELS);

	logic [PIXEL_W-1:0] pixelCount;
	rasterLine_t lineCount;
	logic pixelWrap;
	logic frameWrap;

	timerCount_t reload;
	timerCount_t timer;
	logic timerExpire;
	logic loadNow;

	logic timerIrq;
	logic vblankIrq;
	logic ackTimer;
	logic ackVblank;

	logic [7:0] frameCount;
	aaCount_t aaCount;

	logic irqEnable;
	logic reloadOnLow;
	logic aaDisable;
	logic [7:0] aaSpeed;

	// Mode fields
	assign irqEnable = modeWord[`MODE_TIMER_IRQ];
	assign reloadOnLow = modeWord[`MODE_RELOAD_LOW];
	assign aaDisable = modeWord[`MODE_AA_DISABLE];
	assign aaSpeed = modeWord[15:8];

	assign pixelWrap = pixelCount == PIXEL_W'(`LINE_PIXELS - 1);
	assign frameWrap = pixelWrap && (lineCount == rasterLine_t'(`FRAME_LINES - 1));

	// Pixel and line raster
	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			pixelCount <= '0;
			lineCount <= '0;
		end
		else
		begin
			pixelCount <= pixelWrap ? '0 : pixelCount + 1'b1;
			if (frameWrap)
				lineCount <= '0;
			else if (pixelWrap)
				lineCount <= lineCount + 1'b1;
		end
	end

	// Mode and reload registers
	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			modeWord <= '0;
			reload <= '0;
		end
		else
		begin
			if (regWrite.select[`REG_LSPCMODE])
				modeWord <= regWrite.data;
			if (regWrite.select[`REG_TIMERHIGH])
				reload[31:16] <= regWrite.data;
			if (regWrite.select[`REG_TIMERLOW])
				reload[15:0] <= regWrite.data;
		end
	end

	assign timerExpire = timer == 32'd1;
	assign loadNow = regWrite.select[`REG_TIMERLOW] && reloadOnLow;

	// Down-counter, a reload from a low write beats the expiry reload
	always_ff @(posedge clk24M)
	begin
		if (reset)
			timer <= '0;
		else if (loadNow)
			timer <= {reload[31:16], regWrite.data};
		else if (timerExpire)
			timer <= reload;
		else if (timer != '0)
			timer <= timer - 1'b1;
	end

	assign ackTimer = regWrite.select[`REG_IRQACK] && regWrite.data[0];
	assign ackVblank = regWrite.select[`REG_IRQACK] && regWrite.data[1];

	// Interrupt flags, a set wins over an acknowledge
	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			timerIrq <= 1'b0;
			vblankIrq <= 1'b0;
		end
		else
		begin
			if (timerExpire && irqEnable)
				timerIrq <= 1'b1;
			else if (ackTimer)
				timerIrq <= 1'b0;
			// Rises together with the counters returning to zero
			if (frameWrap)
				vblankIrq <= 1'b1;
			else if (ackVblank)
				vblankIrq <= 1'b0;
		end
	end

	// Auto-animation, one step every aaSpeed + 1 frames
	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			frameCount <= '0;
			aaCount <= '0;
		end
		else if (frameWrap)
		begin
			if (frameCount == aaSpeed)
			begin
				frameCount <= '0;
				if (!aaDisable)
					aaCount <= aaCount + 1'b1;
			end
			else
				frameCount <= frameCount + 1'b1;
		end
	end

	assign status = '{line: lineCount, aaCount: aaCount, vblankIrq: vblankIrq,
		timerIrq: timerIrq};

endmodule

//--- hdl/vramPort.sv
`timescale 1ns/1ps
`include "lspc_defines.svh"

module vramPort
	import lspcPkg::*;
(
	input logic clk24M,
	input logic reset,
	input regWrite_t regWrite,
	output cpuWord_t vramWord,
	output cpuWord_t modWord
);

	localparam int VRAM_WORDS = 1 << `VRAM_AW;

	cpuWord_t vram [VRAM_WORDS];
	vramAddr_t vramAddr;
	logic [`VRAM_AW-1:0] vramIndex;
	logic wrAddr;
	logic wrData;
	logic wrMod;

	assign wrAddr = regWrite.select[`REG_VRAMADDR];
	assign wrData = regWrite.select[`REG_VRAMRW];
	assign wrMod = regWrite.select[`REG_VRAMMOD];

	// Upper address bits are kept but do not reach the array
	assign vramIndex = vramAddr[`VRAM_AW-1:0];

	// Address register with post-access increment by the modulo
	always_ff @(posedge clk24M)
	begin
		if (reset)
			vramAddr <= '0;
		else if (wrAddr)
			vramAddr <= regWrite.data;
		else if (wrData)
			vramAddr <= vramAddr + modWord;
	end

	always_ff @(posedge clk24M)
	begin
		if (reset)
			modWord <= '0;
		else if (wrMod)
			modWord <= regWrite.data;
	end

	// Array write at the address held before the increment
	always_ff @(posedge clk24M)
	begin
		if (wrData)
			vram[vramIndex] <= regWrite.data;
	end

	// Read word follows the address one cycle later, old data on a write
	always_ff @(posedge clk24M)
	begin
		vramWord <= vram[vramIndex];
	end

endmodule

//--- hdl/busPort.sv
`timescale 1ns/1ps
`include "lspc_defines.svh"

module busPort
	import lspcPkg::*;
(
	input logic clk24M,
	input logic reset,
	input logic wrStrobe,
	input logic rdStrobe,
	input regAddr_t regAddr,
	input cpuWord_t wrData,
	input cpuWord_t vramWord,
	input cpuWord_t modWord,
	input cpuWord_t modeWord,
	input rasterStatus_t status,
	output regWrite_t regWrite,
	output cpuWord_t readData,
	output logic rdValid,
	output irqLevel_t ipl
);

	regAddr_t rdAddrQ;
	logic rdPending;
	cpuWord_t statusWord;
	cpuWord_t readMux;

	// Write decode, one select bit per register
	always_ff @(posedge clk24M)
	begin
		if (reset)
			regWrite <= '0;
		else
		begin
			regWrite.select <= wrStrobe ? (8'b1 << regAddr) : 8'b0;
			regWrite.data <= wrData;
		end
	end

	// First read stage holds the address for one cycle
	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			rdPending <= 1'b0;
			rdAddrQ <= '0;
		end
		else
		begin
			rdPending <= rdStrobe;
			rdAddrQ <= regAddr;
		end
	end

	// Raster line on top, tile count at the bottom
	assign statusWord = {status.line, 4'b0000, status.aaCount};

	always_comb
	begin
		case (rdAddrQ)
			`REG_VRAMADDR, `REG_VRAMRW: readMux = vramWord;
			`REG_VRAMMOD: readMux = modWord;
			`REG_LSPCMODE: readMux = statusWord;
			default: readMux = modeWord;
		endcase
	end

	// Second stage returns the word
	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			rdValid <= 1'b0;
			readData <= '0;
		end
		else
		begin
			rdValid <= rdPending;
			if (rdPending)
				readData <= readMux;
		end
	end

	// Vblank takes priority over the timer
	always_comb
	begin
		if (status.vblankIrq)
			ipl = 2'd1;
		else if (status.timerIrq)
			ipl = 2'd2;
		else
			ipl = 2'd0;
	end

endmodule

//--- hdl/lspcPkg.sv
package lspcPkg;

	// CPU data word
	typedef logic [15:0] cpuWord_t;

	// Register select on the CPU address lines
	typedef logic [2:0] regAddr_t;

	// Full VRAM address register, only the low bits reach the array
	typedef logic [15:0] vramAddr_t;

	typedef logic [8:0] rasterLine_t;

	// Auto-animation tile number
	typedef logic [2:0] aaCount_t;

	typedef logic [31:0] timerCount_t;

	// 0 none, 1 vblank, 2 timer
	typedef logic [1:0] irqLevel_t;

	// One decoded CPU write, one-hot on the register address
	typedef struct packed
	{
		logic [7:0] select;
		cpuWord_t data;
	} regWrite_t;

	// Video timing state seen by the bus side
	typedef struct packed
	{
		rasterLine_t line;
		aaCount_t aaCount;
		logic vblankIrq;
		logic timerIrq;
	} rasterStatus_t;

endpackage

//--- hdl/lspc_defines.svh
`ifndef LSPC_DEFINES_SVH
`define LSPC_DEFINES_SVH

// VRAM array depth in address bits
`define VRAM_AW 8

// Raster size, one pixel per clock
`define LINE_PIXELS 24
`define FRAME_LINES 12

// CPU register map
`define REG_VRAMADDR 3'd0
`define REG_VRAMRW 3'd1
`define REG_VRAMMOD 3'd2
`define REG_LSPCMODE 3'd3
`define REG_TIMERHIGH 3'd4
`define REG_TIMERLOW 3'd5
`define REG_IRQACK 3'd6

// Mode register bits
`define MODE_TIMER_IRQ 0
`define MODE_RELOAD_LOW 1
`define MODE_AA_DISABLE 2

`endif
